//--- src/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // datapath sizes, fixed because the struct layouts depend on them
    localparam int WORD_SIZE     = 16;
    localparam int NUM_PHYS_REG  = 64;
    localparam int PREG_W        = $clog2(NUM_PHYS_REG);
    localparam int NUM_FLAGS     = 4;
    localparam int MAX_ROB_TAG_W = 5;

    // bit positions inside a flag vector, NZCV from msb down
    localparam int FLAG_V = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_Z = 2;
    localparam int FLAG_N = 3;

    // branch condition codes, NV is never taken
    typedef enum logic [3:0] {
        EQ, NE, CS, CC,
        MI, PL, VS, VC,
        HI, LS, GE, LT,
        GT, LE, AL, NV
    } bcc_e;

    // what rename hands over on allocation
    typedef struct packed {
        logic [WORD_SIZE-1:0] pc;
        logic [WORD_SIZE-1:0] predicted_pc;
        logic                 is_spec;
        logic                 is_cond_branch;
        logic                 is_store;
        logic                 w_v;
        logic [PREG_W-1:0]    alloc_reg;
        logic [PREG_W-1:0]    freed_reg;
        bcc_e                 bcc_op;
        logic [NUM_FLAGS-1:0] flag_mask;
    } rename_entry_t;

    // one stored buffer entry
    typedef struct packed {
        logic                 valid;
        logic                 wb;
        logic [WORD_SIZE-1:0] pc;
        logic [WORD_SIZE-1:0] predicted_pc;
        logic                 is_spec;
        logic                 is_cond_branch;
        logic                 is_store;
        logic                 w_v;
        logic [PREG_W-1:0]    alloc_reg;
        logic [PREG_W-1:0]    freed_reg;
        bcc_e                 bcc_op;
        logic [NUM_FLAGS-1:0] flag_mask;
        logic [NUM_FLAGS-1:0] flags;
        logic [WORD_SIZE-1:0] resolved_pc;
    } rob_entry_t;

    // one common data bus lane, tag sized for the deepest buffer
    typedef struct packed {
        logic                     valid;
        logic [MAX_ROB_TAG_W-1:0] rob_tag;
        logic [WORD_SIZE-1:0]     result;
        logic [NUM_FLAGS-1:0]     flags;
    } cdb_t;

    // update for the committed rename table
    typedef struct packed {
        logic              w_v;
        logic [PREG_W-1:0] alloc_reg;
        logic [PREG_W-1:0] freed_reg;
    } commit_rename_t;

    typedef struct packed {
        logic [NUM_FLAGS-1:0] mask;
        logic [NUM_FLAGS-1:0] flags;
    } flag_update_t;

endpackage

`default_nettype wire

//--- src/flag_file.sv
`timescale 1ns/1ps
`default_nettype none

module flag_file
    import rob_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            reset_i,
    input  wire logic            upd_valid_i,
    input  flag_update_t         upd_i,
    output logic [NUM_FLAGS-1:0] flags_o
);

    logic [NUM_FLAGS-1:0] flags_q;
    logic [NUM_FLAGS-1:0] flags_n;

    // unmasked bits keep their committed value
    assign flags_n = (flags_q & ~upd_i.mask) | (upd_i.flags & upd_i.mask);

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            flags_q <= '0;
        end
        else if (upd_valid_i)
        begin
            flags_q <= flags_n;
        end
    end

    assign flags_o = flags_q;

endmodule

`default_nettype wire

//--- src/commit_unit.sv
`timescale 1ns/1ps
`default_nettype none

module commit_unit
    import rob_pkg::*;
(
    input  rob_entry_t                head_i,
    input  wire logic [NUM_FLAGS-1:0] flags_i,
    output logic                      retire_o,
    output logic                      flush_o,
    output logic                      phys_valid_o,
    output logic [PREG_W-1:0]         phys_clear_o,
    output logic [PREG_W-1:0]         phys_set_o,
    output logic                      sb_pop_o,
    output logic                      commit_rename_valid_o,
    output commit_rename_t            commit_rename_o,
    output logic                      flag_upd_valid_o,
    output flag_update_t              flag_upd_o,
    output logic [WORD_SIZE-1:0]      redirect_pc_o
);

    logic                 n_f;
    logic                 z_f;
    logic                 c_f;
    logic                 v_f;
    logic                 taken;
    logic                 commit_ok;
    logic [WORD_SIZE-1:0] next_pc;

    assign n_f = flags_i[FLAG_N];
    assign z_f = flags_i[FLAG_Z];
    assign c_f = flags_i[FLAG_C];
    assign v_f = flags_i[FLAG_V];

    // condition code against the architectural flags
    always_comb
    begin
        unique case (head_i.bcc_op)
            EQ: taken = z_f;
            NE: taken = !z_f;
            CS: taken = c_f;
            CC: taken = !c_f;
            MI: taken = n_f;
            PL: taken = !n_f;
            VS: taken = v_f;
            VC: taken = !v_f;
            HI: taken = c_f && !z_f;
            LS: taken = !c_f || z_f;
            GE: taken = (n_f == v_f);
            LT: taken = (n_f != v_f);
            GT: taken = !z_f && (n_f == v_f);
            LE: taken = z_f || (n_f != v_f);
            AL: taken = 1'b1;
            NV: taken = 1'b0;
        endcase
    end

    // not-taken conditional branch falls through to the next word
    always_comb
    begin
        if (head_i.is_cond_branch && !taken)
            next_pc = head_i.pc + WORD_SIZE'(1);
        else
            next_pc = head_i.resolved_pc;
    end

    // resolved_pc only holds a real value once the entry is written back
    assign flush_o = head_i.valid && head_i.wb && head_i.is_spec
                     && (head_i.predicted_pc != next_pc);
    assign redirect_pc_o = next_pc;

    assign commit_ok = head_i.valid && head_i.wb && !flush_o;
    assign retire_o  = commit_ok;

    // register writers other than stores
    assign phys_valid_o = commit_ok && head_i.w_v && !head_i.is_store;
    assign phys_clear_o = head_i.freed_reg;
    assign phys_set_o   = head_i.alloc_reg;

    assign sb_pop_o = commit_ok && head_i.is_store;

    assign commit_rename_valid_o     = commit_ok;
    assign commit_rename_o.w_v       = head_i.w_v;
    assign commit_rename_o.alloc_reg = head_i.alloc_reg;
    assign commit_rename_o.freed_reg = head_i.freed_reg;

    assign flag_upd_valid_o = commit_ok && (|head_i.flag_mask);
    assign flag_upd_o.mask  = head_i.flag_mask;
    assign flag_upd_o.flags = head_i.flags;

endmodule

`default_nettype wire

//--- src/rob_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rob_buffer
    import rob_pkg::*;
#(
    parameter int ROB_ENTRY = 8,
    parameter int NUM_FU    = 2
)
(
    input  wire logic                         clk_i,
    input  wire logic                         reset_i,
    input  wire logic                         alloc_valid_i,
    input  rename_entry_t                     alloc_entry_i,
    output logic                              alloc_ready_o,
    output logic [$clog2(ROB_ENTRY)-1:0]      alloc_tag_o,
    input  cdb_t                              cdb_i [NUM_FU],
    input  wire logic                         retire_i,
    input  wire logic                         flush_i,
    output rob_entry_t                        head_o
);

    localparam int TAG_W = $clog2(ROB_ENTRY);
    localparam logic [TAG_W:0] DEPTH = (TAG_W + 1)'(ROB_ENTRY);

    // payload storage, valid and wb live in the control vectors
    rob_entry_t           entry_q [ROB_ENTRY];
    logic [ROB_ENTRY-1:0] valid_q;
    logic [ROB_ENTRY-1:0] wb_q;
    logic [ROB_ENTRY-1:0] valid_n;
    logic [ROB_ENTRY-1:0] wb_n;
    logic [TAG_W-1:0]     alloc_ptr_q;
    logic [TAG_W-1:0]     commit_ptr_q;
    logic [TAG_W:0]       count_q;

    logic                 full;
    logic                 alloc_fire;
    rob_entry_t           alloc_rec;
    logic [ROB_ENTRY-1:0] wb_hit;
    cdb_t                 wb_sel [ROB_ENTRY];

    // wrap at the depth, which need not be a power of two
    function automatic logic [TAG_W-1:0] ptr_inc(input logic [TAG_W-1:0] ptr);
        if (ptr == TAG_W'(ROB_ENTRY - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    assign full          = (count_q == DEPTH);
    assign alloc_ready_o = !full && !flush_i;
    assign alloc_tag_o   = alloc_ptr_q;
    assign alloc_fire    = alloc_valid_i && alloc_ready_o;

    always_comb
    begin
        alloc_rec                = '0;
        alloc_rec.pc             = alloc_entry_i.pc;
        alloc_rec.predicted_pc   = alloc_entry_i.predicted_pc;
        alloc_rec.is_spec        = alloc_entry_i.is_spec;
        alloc_rec.is_cond_branch = alloc_entry_i.is_cond_branch;
        alloc_rec.is_store       = alloc_entry_i.is_store;
        alloc_rec.w_v            = alloc_entry_i.w_v;
        alloc_rec.alloc_reg      = alloc_entry_i.alloc_reg;
        alloc_rec.freed_reg      = alloc_entry_i.freed_reg;
        alloc_rec.bcc_op         = alloc_entry_i.bcc_op;
        alloc_rec.flag_mask      = alloc_entry_i.flag_mask;
    end

    // per entry tag match, the highest lane index wins
    always_comb
    begin
        for (int i = 0; i < ROB_ENTRY; i++)
        begin
            wb_hit[i] = 1'b0;
            wb_sel[i] = '0;
            for (int j = 0; j < NUM_FU; j++)
            begin
                if (cdb_i[j].valid && valid_q[i] && !wb_q[i]
                    && cdb_i[j].rob_tag[TAG_W-1:0] == TAG_W'(i))
                begin
                    wb_hit[i] = 1'b1;
                    wb_sel[i] = cdb_i[j];
                end
            end
        end
    end

    always_comb
    begin
        valid_n = valid_q;
        wb_n    = wb_q | wb_hit;
        if (alloc_fire)
        begin
            valid_n[alloc_ptr_q] = 1'b1;
            wb_n[alloc_ptr_q]    = 1'b0;
        end
        if (retire_i)
        begin
            valid_n[commit_ptr_q] = 1'b0;
            wb_n[commit_ptr_q]    = 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        for (int i = 0; i < ROB_ENTRY; i++)
        begin
            if (alloc_fire && alloc_ptr_q == TAG_W'(i))
            begin
                entry_q[i] <= alloc_rec;
            end
            else if (wb_hit[i])
            begin
                entry_q[i].flags <= wb_sel[i].flags;
                // branch target or jump address arrives as the result
                if (entry_q[i].is_spec)
                    entry_q[i].resolved_pc <= wb_sel[i].result;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i || flush_i)
        begin
            valid_q      <= '0;
            wb_q         <= '0;
            alloc_ptr_q  <= '0;
            commit_ptr_q <= '0;
            count_q      <= '0;
        end
        else
        begin
            valid_q <= valid_n;
            wb_q    <= wb_n;
            count_q <= count_q + (TAG_W + 1)'(alloc_fire) - (TAG_W + 1)'(retire_i);
            if (alloc_fire)
                alloc_ptr_q <= ptr_inc(alloc_ptr_q);
            if (retire_i)
                commit_ptr_q <= ptr_inc(commit_ptr_q);
        end
    end

    always_comb
    begin
        head_o       = entry_q[commit_ptr_q];
        head_o.valid = valid_q[commit_ptr_q];
        head_o.wb    = wb_q[commit_ptr_q];
    end

    // allocation only ever lands on a free slot
    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_fire |-> !valid_q[alloc_ptr_q]);

    // commit side may only retire a written-back head
    a_retire_wb: assert property (@(posedge clk_i) disable iff (reset_i)
        retire_i |-> wb_q[commit_ptr_q]);

endmodule

`default_nettype wire

//--- src/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import rob_pkg::*;
#(
    parameter int ROB_ENTRY = 8,
    parameter int NUM_FU    = 2
)
(
    input  wire logic                    clk_i,
    input  wire logic                    reset_i,
    input  wire logic                    rename_valid_i,
    output logic                         rename_ready_o,
    input  rename_entry_t                rename_entry_i,
    output logic [$clog2(ROB_ENTRY)-1:0] rename_tag_o,
    input  cdb_t                         cdb_i [NUM_FU],
    output logic                         phys_valid_o,
    output logic [PREG_W-1:0]            phys_clear_o,
    output logic [PREG_W-1:0]            phys_set_o,
    output logic                         sb_pop_o,
    output logic                         commit_rename_valid_o,
    output commit_rename_t               commit_rename_o,
    output logic                         mispredict_o,
    output logic [WORD_SIZE-1:0]         redirect_pc_o,
    output logic [NUM_FLAGS-1:0]         flags_o
);

    rob_entry_t           head;
    logic                 retire;
    logic                 flush;
    logic                 flag_upd_valid;
    flag_update_t         flag_upd;
    logic [NUM_FLAGS-1:0] flags;

    rob_buffer #(
        .ROB_ENTRY (ROB_ENTRY),
        .NUM_FU    (NUM_FU)
    ) u_buffer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_valid_i (rename_valid_i),
        .alloc_entry_i (rename_entry_i),
        .alloc_ready_o (rename_ready_o),
        .alloc_tag_o   (rename_tag_o),
        .cdb_i         (cdb_i),
        .retire_i      (retire),
        .flush_i       (flush),
        .head_o        (head)
    );

    commit_unit u_commit (
        .head_i                (head),
        .flags_i               (flags),
        .retire_o              (retire),
        .flush_o               (flush),
        .phys_valid_o          (phys_valid_o),
        .phys_clear_o          (phys_clear_o),
        .phys_set_o            (phys_set_o),
        .sb_pop_o              (sb_pop_o),
        .commit_rename_valid_o (commit_rename_valid_o),
        .commit_rename_o       (commit_rename_o),
        .flag_upd_valid_o      (flag_upd_valid),
        .flag_upd_o            (flag_upd),
        .redirect_pc_o         (redirect_pc_o)
    );

    flag_file u_flags (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .upd_valid_i (flag_upd_valid),
        .upd_i       (flag_upd),
        .flags_o     (flags)
    );

    // flush doubles as the frontend redirect strobe
    assign mispredict_o = flush;
    assign flags_o      = flags;

endmodule

`default_nettype wire

//--- sim/rob_tb_model.svh
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// one expected commit, pushed in program order
typedef struct packed {
    logic                 mispredict;
    logic                 is_store;
    logic                 w_v;
    logic [PREG_W-1:0]    alloc_reg;
    logic [PREG_W-1:0]    freed_reg;
    logic [WORD_SIZE-1:0] redirect_pc;
    logic [NUM_FLAGS-1:0] flag_mask;
    logic [NUM_FLAGS-1:0] flags;
} exp_commit_t;

exp_commit_t          exp_q [$];
// flags as seen by the next entry in program order
logic [NUM_FLAGS-1:0] stim_flags;

// take each masked bit from the new value, keep the rest
function automatic logic [NUM_FLAGS-1:0] masked_update(input logic [NUM_FLAGS-1:0] old,
    input logic [NUM_FLAGS-1:0] mask, input logic [NUM_FLAGS-1:0] val);
    logic [NUM_FLAGS-1:0] r;
    r = old;
    for (int b = 0; b < NUM_FLAGS; b++)
    begin
        if (mask[b])
            r[b] = val[b];
    end
    return r;
endfunction

// codes come in pairs, the odd code inverts the even one
function automatic logic cond_taken(input bcc_e op, input logic [NUM_FLAGS-1:0] nzcv);
    logic [3:0] code;
    logic       n;
    logic       z;
    logic       c;
    logic       v;
    logic       base;
    code = op;
    n = nzcv[FLAG_N];
    z = nzcv[FLAG_Z];
    c = nzcv[FLAG_C];
    v = nzcv[FLAG_V];
    case (code[3:1])
        3'd0: base = z;
        3'd1: base = c;
        3'd2: base = n;
        3'd3: base = v;
        3'd4: base = c && !z;
        3'd5: base = (n == v);
        3'd6: base = !z && (n == v);
        default: base = 1'b1;
    endcase
    return code[0] ? !base : base;
endfunction

function automatic logic [WORD_SIZE-1:0] expected_next_pc(input rename_entry_t e,
    input logic [NUM_FLAGS-1:0] nzcv, input logic [WORD_SIZE-1:0] result);
    if (e.is_cond_branch && !cond_taken(e.bcc_op, nzcv))
        return e.pc + WORD_SIZE'(1);
    return result;
endfunction

function automatic void expect_entry(input rename_entry_t e,
    input logic [NUM_FLAGS-1:0] fl, input logic [WORD_SIZE-1:0] result);
    exp_commit_t r;
    r.redirect_pc = expected_next_pc(e, stim_flags, result);
    r.mispredict  = e.is_spec && (e.predicted_pc != r.redirect_pc);
    r.is_store    = e.is_store;
    r.w_v         = e.w_v;
    r.alloc_reg   = e.alloc_reg;
    r.freed_reg   = e.freed_reg;
    r.flag_mask   = e.flag_mask;
    r.flags       = fl;
    // a mispredicted entry leaves the flags alone
    if (!r.mispredict)
        stim_flags = masked_update(stim_flags, e.flag_mask, fl);
    exp_q.push_back(r);
endfunction

`endif

//--- sim/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb
    import rob_pkg::*;
();

    localparam int ROB_ENTRY = 8;
    localparam int NUM_FU    = 2;
    localparam int TAG_W     = $clog2(ROB_ENTRY);
    // steps per test: reset 1, order 8, full 9, store and flags 3, branch 32, flush 4
    localparam int TIMEOUT_CYCLES = 40 * (1 + 8 + 9 + 3 + 32 + 4);

    logic                 clk;
    logic                 reset;
    logic                 rename_valid;
    logic                 rename_ready;
    rename_entry_t        rename_entry;
    logic [TAG_W-1:0]     rename_tag;
    cdb_t                 cdb [NUM_FU];
    logic                 phys_valid;
    logic [PREG_W-1:0]    phys_clear;
    logic [PREG_W-1:0]    phys_set;
    logic                 sb_pop;
    logic                 commit_rename_valid;
    commit_rename_t       commit_rename;
    logic                 mispredict;
    logic [WORD_SIZE-1:0] redirect_pc;
    logic [NUM_FLAGS-1:0] flags;
    logic [NUM_FLAGS-1:0] chk_flags;
    logic [31:0]          lfsr_q;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   failed_tests;
    int                   test_errors0;
    int                   cycles;

    `include "rob_tb_model.svh"

    rob_top #(
        .ROB_ENTRY (ROB_ENTRY),
        .NUM_FU    (NUM_FU)
    ) dut0 (
        .clk_i                 (clk),
        .reset_i               (reset),
        .rename_valid_i        (rename_valid),
        .rename_ready_o        (rename_ready),
        .rename_entry_i        (rename_entry),
        .rename_tag_o          (rename_tag),
        .cdb_i                 (cdb),
        .phys_valid_o          (phys_valid),
        .phys_clear_o          (phys_clear),
        .phys_set_o            (phys_set),
        .sb_pop_o              (sb_pop),
        .commit_rename_valid_o (commit_rename_valid),
        .commit_rename_o       (commit_rename),
        .mispredict_o          (mispredict),
        .redirect_pc_o         (redirect_pc),
        .flags_o               (flags)
    );

    always #2 clk = ~clk;

    // 32 bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic rename_entry_t make_entry();
        rename_entry_t e;
        e = '0;
        e.pc        = WORD_SIZE'(random_bits(WORD_SIZE));
        e.w_v       = 1'b1;
        e.alloc_reg = PREG_W'(random_bits(PREG_W));
        e.freed_reg = PREG_W'(random_bits(PREG_W));
        e.bcc_op    = AL;
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic allocate(input rename_entry_t e, output logic [TAG_W-1:0] tag);
        logic ok;
        rename_valid = 1'b1;
        rename_entry = e;
        ok = 1'b0;
        while (!ok)
        begin
            @(negedge clk);
            ok  = rename_ready;
            tag = rename_tag;
            step();
        end
        rename_valid = 1'b0;
    endtask

    task automatic writeback(input logic [TAG_W-1:0] tag, input int lane,
        input logic [WORD_SIZE-1:0] result, input logic [NUM_FLAGS-1:0] fl);
        cdb[lane] = '{valid: 1'b1, rob_tag: MAX_ROB_TAG_W'(tag), result: result, flags: fl};
        step();
        cdb[lane] = '0;
    endtask

    task automatic run_entry(input rename_entry_t e, input logic [WORD_SIZE-1:0] result);
        logic [TAG_W-1:0]     tag;
        logic [NUM_FLAGS-1:0] fl;
        fl = NUM_FLAGS'(random_bits(NUM_FLAGS));
        allocate(e, tag);
        expect_entry(e, fl, result);
        writeback(tag, int'(random_bits(1)), result, fl);
    endtask

    // commits pop the queue at the falling edge
    task automatic drain();
        do
            @(posedge clk);
        while (exp_q.size() != 0);
        #1;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_errors0)
            failed_tests++;
        $display("test %0s finished with %0d errors", name, errors - test_errors0);
        test_errors0 = errors;
    endtask

    // compare every commit against the oldest expected one
    always @(negedge clk)
    begin
        exp_commit_t e;
        if (!reset)
        begin
            compare_value("flags_o", 32'(flags), 32'(chk_flags));
            if (commit_rename_valid || mispredict || phys_valid || sb_pop)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("a commit strobe came while no commit was expected");
                end
                else
                begin
                    e = exp_q.pop_front();
                    compare_value("mispredict_o", 32'(mispredict), 32'(e.mispredict));
                    if (e.mispredict)
                    begin
                        compare_value("redirect_pc_o", 32'(redirect_pc), 32'(e.redirect_pc));
                        compare_value("rename_ready_o", 32'(rename_ready), 0);
                        compare_value("{commit_rename_valid_o,phys_valid_o,sb_pop_o}",
                            32'({commit_rename_valid, phys_valid, sb_pop}), 0);
                    end
                    else
                    begin
                        compare_value("commit_rename_valid_o", 32'(commit_rename_valid), 1);
                        compare_value("phys_valid_o", 32'(phys_valid),
                            32'(e.w_v && !e.is_store));
                        compare_value("sb_pop_o", 32'(sb_pop), 32'(e.is_store));
                        compare_value("commit_rename_o", 32'(commit_rename),
                            32'({e.w_v, e.alloc_reg, e.freed_reg}));
                        if (e.w_v && !e.is_store)
                        begin
                            compare_value("phys_set_o", 32'(phys_set), 32'(e.alloc_reg));
                            compare_value("phys_clear_o", 32'(phys_clear), 32'(e.freed_reg));
                        end
                        chk_flags = masked_update(chk_flags, e.flag_mask, e.flags);
                    end
                end
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        rename_entry_t        e;
        rename_entry_t        ents [ROB_ENTRY+1];
        logic [TAG_W-1:0]     tags [ROB_ENTRY+1];
        int                   order [ROB_ENTRY];
        int                   j;
        int                   tmp;
        logic [WORD_SIZE-1:0] target;
        logic [WORD_SIZE-1:0] next;
        clk          = 1'b0;
        reset        = 1'b1;
        rename_valid = 1'b0;
        rename_entry = '0;
        for (int i = 0; i < NUM_FU; i++)
            cdb[i] = '0;
        lfsr_q       = 32'h39c0_c5ad;
        stim_flags   = '0;
        chk_flags    = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        test_errors0 = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        compare_value("rename_ready_o", 32'(rename_ready), 1);
        compare_value("rename_tag_o", 32'(rename_tag), 0);
        compare_value("flags_o", 32'(flags), 0);
        compare_value("{phys_valid_o,sb_pop_o,commit_rename_valid_o,mispredict_o}",
            32'({phys_valid, sb_pop, commit_rename_valid, mispredict}), 0);
        step();
        end_test("after reset");

        for (int i = 0; i < ROB_ENTRY; i++)
        begin
            ents[i] = make_entry();
            allocate(ents[i], tags[i]);
            expect_entry(ents[i], '0, '0);
            order[i] = i;
        end
        // shuffled writeback, alternating lanes
        for (int i = ROB_ENTRY - 1; i > 0; i--)
        begin
            j = int'(random_bits(3)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < ROB_ENTRY; i++)
            writeback(tags[order[i]], i % NUM_FU, WORD_SIZE'(random_bits(WORD_SIZE)), '0);
        drain();
        end_test("ordered retirement");

        // one full lap before this test, so tags start again at 0
        for (int i = 0; i < ROB_ENTRY; i++)
        begin
            ents[i] = make_entry();
            allocate(ents[i], tags[i]);
            compare_value("rename_tag_o", 32'(tags[i]), i);
            expect_entry(ents[i], '0, '0);
        end
        ents[ROB_ENTRY] = make_entry();
        rename_valid = 1'b1;
        rename_entry = ents[ROB_ENTRY];
        repeat (2)
        begin
            @(negedge clk);
            compare_value("rename_ready_o", 32'(rename_ready), 0);
            step();
        end
        writeback(tags[0], 0, '0, '0);
        allocate(ents[ROB_ENTRY], tags[ROB_ENTRY]);
        expect_entry(ents[ROB_ENTRY], '0, '0);
        // the held entry takes the slot freed by the head
        compare_value("rename_tag_o", 32'(tags[ROB_ENTRY]), 0);
        @(negedge clk);
        compare_value("rename_ready_o", 32'(rename_ready), 0);
        step();
        for (int i = 1; i <= ROB_ENTRY; i++)
            writeback(tags[i], i % NUM_FU, '0, '0);
        drain();
        end_test("full buffer");

        // store, then full flag write, then a partial one
        for (int i = 0; i < 3; i++)
        begin
            e = make_entry();
            e.is_store  = (i == 0);
            e.flag_mask = (i == 1) ? 4'hf : NUM_FLAGS'(random_bits(NUM_FLAGS));
            if (i == 2 && (e.flag_mask == '0 || e.flag_mask == 4'hf))
                e.flag_mask = 4'b0101;
            run_entry(e, '0);
        end
        drain();
        end_test("stores and flags");

        for (int c = 0; c < 16; c++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                e = make_entry();
                e.flag_mask = 4'hf;
                run_entry(e, '0);
                e = make_entry();
                e.w_v            = 1'b0;
                e.is_spec        = 1'b1;
                e.is_cond_branch = 1'b1;
                e.bcc_op         = bcc_e'(c);
                target = WORD_SIZE'(random_bits(WORD_SIZE));
                next   = expected_next_pc(e, stim_flags, target);
                e.predicted_pc = (k == 0) ? next : ~next;
                run_entry(e, target);
                drain();
            end
        end
        end_test("conditional branches");

        // jump with a wrong target, younger entries written back first
        e = make_entry();
        e.w_v     = 1'b0;
        e.is_spec = 1'b1;
        target    = WORD_SIZE'(random_bits(WORD_SIZE));
        e.predicted_pc = target + WORD_SIZE'(5);
        allocate(e, tags[0]);
        expect_entry(e, '0, target);
        for (int i = 1; i < 4; i++)
        begin
            ents[i] = make_entry();
            ents[i].flag_mask = 4'hf;
            allocate(ents[i], tags[i]);
        end
        for (int i = 1; i < 4; i++)
            writeback(tags[i], i % NUM_FU, '0, NUM_FLAGS'(random_bits(NUM_FLAGS)));
        writeback(tags[0], 0, target, '0);
        drain();
        @(negedge clk);
        compare_value("rename_ready_o", 32'(rename_ready), 1);
        compare_value("rename_tag_o", 32'(rename_tag), 0);
        repeat (4) step();
        end_test("flush");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
            tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
src/rob_pkg.sv
src/flag_file.sv
src/commit_unit.sv
src/rob_buffer.sv
src/rob_top.sv
sim/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
